// ==== sources.f ====
design/tetrisPkg.sv
design/keyDecoder.sv
design/pieceGenerator.sv
design/holdSlot.sv
design/gameControl.sv
design/tetrisControlTop.sv
verif/tetrisControl_asserts.sv
verif/tetrisControlTb.sv

// ==== Bender.yml ====
package:
  name: tetris_control

sources:
  - files:
      - design/tetrisPkg.sv
      - design/keyDecoder.sv
      - design/pieceGenerator.sv
      - design/holdSlot.sv
      - design/gameControl.sv
      - design/tetrisControlTop.sv

  - target: test
    files:
      - verif/tetrisControl_asserts.sv
      - verif/tetrisControlTb.sv

// ==== verif/tetrisControlTb.sv ====
`timescale 1ns/100ps

module tetrisControlTb;

	// Commands of the test list.
	typedef enum
	{
		cmdStart,
		cmdLand,
		cmdHold,
		cmdPause,
		cmdQuit
	} commandT;

	logic                   Clk;
	logic                   arstN;
	logic [7:0]             keycode;
	logic                   hitBottom;
	tetrisPkg::pieceShapeT  activeShape;
	tetrisPkg::spriteIndexT activeSprite;
	tetrisPkg::pieceShapeT  nextShape;
	tetrisPkg::spriteIndexT nextSprite;
	tetrisPkg::pieceShapeT  heldShape;
	tetrisPkg::spriteIndexT heldSprite;
	logic                   heldValid;
	logic                   resetBlocks;
	logic                   pause;

	commandT testList [0:16] = '{cmdStart, cmdLand, cmdLand, cmdHold, cmdHold, cmdLand,
		cmdHold, cmdLand, cmdPause, cmdLand, cmdHold, cmdPause, cmdLand, cmdQuit, cmdLand,
		cmdStart, cmdLand};

	integer seed = 32'h3bf5;
	string  testName;
	int     pulseCount = 0;  // resetBlocks pulses seen so far.
	int     expPulses;

	// Model of the piece registers, as sequence indices.
	tetrisPkg::gameStateT mode;
	int                   nextIdx;
	int                   activeIdx;  // -1 while no piece was ever spawned.
	int                   heldIdx;
	logic                 modelHeldValid;
	logic                 modelCanHold;

	tetrisControlTop i_tetrisControlTop (
		.Clk          (Clk),
		.arstN        (arstN),
		.keycode      (keycode),
		.hitBottom    (hitBottom),
		.activeShape  (activeShape),
		.activeSprite (activeSprite),
		.nextShape    (nextShape),
		.nextSprite   (nextSprite),
		.heldShape    (heldShape),
		.heldSprite   (heldSprite),
		.heldValid    (heldValid),
		.resetBlocks  (resetBlocks),
		.pause        (pause)
	);

	initial
	begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk;  // 4 ns period.
	end

	// Watchdog allowing 40 cycles per command plus reset.
	initial
	begin
		#(($size(testList) * 40 + 5) * 4);
		$display("Timeout: the test list did not complete in the expected time.");
		failRun();
	end

	// Reference model --------------
	function automatic logic [15:0] lfsrAt(input int n);
		logic [15:0] value;
		logic        feedback;
		value = tetrisPkg::lfsrSeed;
		for (int i = 0; i < n; i++)
		begin
			feedback = ^(value & tetrisPkg::lfsrTaps);
			value    = {feedback, value[15:1]};  // Shift right, feedback on top.
		end
		return value;
	endfunction

	function automatic tetrisPkg::pieceShapeT elementShape(input int n);
		if (n < 0)
			return '0;
		return tetrisPkg::pieceShapes[lfsrAt(n) % tetrisPkg::numKinds];
	endfunction

	function automatic tetrisPkg::spriteIndexT elementSprite(input int n);
		if (n < 0)
			return '0;
		return tetrisPkg::pieceSprites[lfsrAt(n) % tetrisPkg::numKinds];
	endfunction

	// Compare tasks --------------
	task automatic failRun();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic checkShape(input string name, input tetrisPkg::pieceShapeT expected,
		input tetrisPkg::pieceShapeT actual);
		if (actual !== expected)
		begin
			$display("FAILED %s, %s: expected %h, actual %h", testName, name, expected, actual);
			failRun();
		end
	endtask

	task automatic checkSprite(input string name, input tetrisPkg::spriteIndexT expected,
		input tetrisPkg::spriteIndexT actual);
		if (actual !== expected)
		begin
			$display("FAILED %s, %s: expected %0d, actual %0d", testName, name, expected, actual);
			failRun();
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("FAILED %s, %s: expected %b, actual %b", testName, name, expected, actual);
			failRun();
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		if (actual != expected)
		begin
			$display("FAILED %s, %s: expected %0d, actual %0d", testName, name, expected, actual);
			failRun();
		end
	endtask

	// Every spawn must show the next sequence element while pause is low.
	always @(negedge Clk)
	begin
		if (arstN && resetBlocks)
		begin
			checkFlag("pause during resetBlocks", 1'b0, pause);
			checkShape("picked shape", elementShape(pulseCount), nextShape);
			checkSprite("picked sprite", elementSprite(pulseCount), nextSprite);
			pulseCount = pulseCount + 1;
		end
	end

	task automatic checkOutputs();
		checkCount("resetBlocks pulses", expPulses, pulseCount);
		checkFlag("resetBlocks", 1'b0, resetBlocks);
		checkFlag("pause", mode != tetrisPkg::falling, pause);
		checkShape("active shape", elementShape(activeIdx), activeShape);
		checkSprite("active sprite", elementSprite(activeIdx), activeSprite);
		checkShape("next shape", elementShape(nextIdx), nextShape);
		checkSprite("next sprite", elementSprite(nextIdx), nextSprite);
		checkFlag("heldValid", modelHeldValid, heldValid);
		checkShape("held shape", elementShape(heldIdx), heldShape);
		checkSprite("held sprite", elementSprite(heldIdx), heldSprite);
	endtask

	// Stimulus --------------
	task automatic pressKey(input logic [7:0] code);
		@(posedge Clk);
		keycode <= code;
		@(posedge Clk);
		keycode <= tetrisPkg::keyIdle;  // Release between presses.
	endtask

	task automatic dropPiece();
		int waitCycles;
		waitCycles = ($random(seed) & 7) + 1;
		repeat (waitCycles) @(posedge Clk);
		hitBottom <= 1'b1;
		repeat (2) @(posedge Clk);
		hitBottom <= 1'b0;
	endtask

	task automatic spawnPiece();
		activeIdx = nextIdx;
		nextIdx   = nextIdx + 1;
		expPulses = expPulses + 1;
	endtask

	// The model is updated before the matching stimulus is driven.
	task automatic runCommand(input commandT cmd);
		int swapIdx;
		case (cmd)
			cmdStart:
			begin
				if (mode == tetrisPkg::waitStart)
				begin
					spawnPiece();
					mode = tetrisPkg::falling;
				end
				pressKey(tetrisPkg::keyStart);
			end
			cmdLand:
			begin
				if (mode == tetrisPkg::falling)
				begin
					modelCanHold = 1'b1;
					spawnPiece();
				end
				dropPiece();
			end
			cmdHold:
			begin
				if (mode == tetrisPkg::falling && modelCanHold)
				begin
					modelCanHold = 1'b0;
					if (modelHeldValid)
					begin
						swapIdx   = heldIdx;  // Swap without a new pick.
						heldIdx   = activeIdx;
						activeIdx = swapIdx;
					end
					else
					begin
						heldIdx        = activeIdx;
						modelHeldValid = 1'b1;
						spawnPiece();
					end
				end
				pressKey(tetrisPkg::keyHold);
			end
			cmdPause:
			begin
				if (mode == tetrisPkg::falling)
					mode = tetrisPkg::paused;
				else if (mode == tetrisPkg::paused)
					mode = tetrisPkg::falling;
				pressKey(tetrisPkg::keyPause);
			end
			default:
			begin
				mode = tetrisPkg::waitStart;  // Quit from falling or paused.
				pressKey(tetrisPkg::keyQuit);
			end
		endcase
	endtask

	// Waits for the expected spawns, then for the FSM to come back to rest.
	task automatic settle();
		wait (pulseCount >= expPulses);
		repeat (4) @(posedge Clk);
		@(negedge Clk);
	endtask

	initial
	begin
		arstN          = 1'b0;
		keycode        = tetrisPkg::keyIdle;
		hitBottom      = 1'b0;
		mode           = tetrisPkg::waitStart;
		nextIdx        = 0;
		activeIdx      = -1;
		heldIdx        = -1;
		modelHeldValid = 1'b0;
		modelCanHold   = 1'b1;
		expPulses      = 0;
		testName       = "reset";
		repeat (5) @(posedge Clk);
		arstN <= 1'b1;
		@(negedge Clk);
		checkOutputs();
		foreach (testList[i])
		begin
			testName = $sformatf("step %0d %s", i, testList[i].name());
			runCommand(testList[i]);
			settle();
			checkOutputs();
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== verif/tetrisControl_asserts.sv ====
`timescale 1ns/100ps

module tetrisControl_asserts
(
	input logic Clk,
	input logic arstN,
	input logic resetBlocks,
	input logic pause,
	input logic heldValid
);

	// Spawn strobe --------------
	assert property (@(posedge Clk) disable iff (!arstN) resetBlocks |=> !resetBlocks)
	else $error("resetBlocks was high in two consecutive cycles.");

	// The board only gets a new piece while the game runs.
	assert property (@(posedge Clk) disable iff (!arstN) resetBlocks |-> !pause)
	else $error("resetBlocks was high while pause was high.");

	// Hold slot --------------
	assert property (@(posedge Clk) disable iff (!arstN) !$fell(heldValid))
	else $error("heldValid fell outside of reset.");

endmodule

bind tetrisControlTop tetrisControl_asserts i_tetrisControlAsserts (
	.Clk         (Clk),
	.arstN       (arstN),
	.resetBlocks (resetBlocks),
	.pause       (pause),
	.heldValid   (heldValid)
);

// ==== design/tetrisControlTop.sv ====
`timescale 1ns/100ps

module tetrisControlTop
(
	input  logic                   Clk,
	input  logic                   arstN,
	input  logic [7:0]             keycode,
	input  logic                   hitBottom,
	output tetrisPkg::pieceShapeT  activeShape,
	output tetrisPkg::spriteIndexT activeSprite,
	output tetrisPkg::pieceShapeT  nextShape,
	output tetrisPkg::spriteIndexT nextSprite,
	output tetrisPkg::pieceShapeT  heldShape,
	output tetrisPkg::spriteIndexT heldSprite,
	output logic                   heldValid,
	output logic                   resetBlocks,
	output logic                   pause
);

	// Command pulses.
	logic startPress;
	logic pausePress;
	logic holdPress;
	logic quitPress;

	// Strobes and flags between the FSM and its neighbours.
	logic pickPiece;
	logic storePiece;
	logic rearmHold;
	logic canHold;

	keyDecoder i_keyDecoder (
		.Clk        (Clk),
		.arstN      (arstN),
		.keycode    (keycode),
		.startPress (startPress),
		.pausePress (pausePress),
		.holdPress  (holdPress),
		.quitPress  (quitPress)
	);

	pieceGenerator i_pieceGenerator (
		.Clk        (Clk),
		.arstN      (arstN),
		.pickPiece  (pickPiece),
		.nextShape  (nextShape),
		.nextSprite (nextSprite)
	);

	holdSlot i_holdSlot (
		.Clk          (Clk),
		.arstN        (arstN),
		.storePiece   (storePiece),
		.rearmHold    (rearmHold),
		.activeShape  (activeShape),
		.activeSprite (activeSprite),
		.heldShape    (heldShape),
		.heldSprite   (heldSprite),
		.heldValid    (heldValid),
		.canHold      (canHold)
	);

	gameControl i_gameControl (
		.Clk          (Clk),
		.arstN        (arstN),
		.startPress   (startPress),
		.pausePress   (pausePress),
		.holdPress    (holdPress),
		.quitPress    (quitPress),
		.hitBottom    (hitBottom),
		.nextShape    (nextShape),
		.nextSprite   (nextSprite),
		.heldShape    (heldShape),
		.heldSprite   (heldSprite),
		.heldValid    (heldValid),
		.canHold      (canHold),
		.activeShape  (activeShape),
		.activeSprite (activeSprite),
		.pickPiece    (pickPiece),
		.storePiece   (storePiece),
		.rearmHold    (rearmHold),
		.resetBlocks  (resetBlocks),
		.pause        (pause)
	);

endmodule

// ==== design/gameControl.sv ====
`timescale 1ns/100ps

module gameControl
(
	input  logic                   Clk,
	input  logic                   arstN,
	input  logic                   startPress,
	input  logic                   pausePress,
	input  logic                   holdPress,
	input  logic                   quitPress,
	input  logic                   hitBottom,
	input  tetrisPkg::pieceShapeT  nextShape,
	input  tetrisPkg::spriteIndexT nextSprite,
	input  tetrisPkg::pieceShapeT  heldShape,
	input  tetrisPkg::spriteIndexT heldSprite,
	input  logic                   heldValid,
	input  logic                   canHold,
	output tetrisPkg::pieceShapeT  activeShape,
	output tetrisPkg::spriteIndexT activeSprite,
	output logic                   pickPiece,
	output logic                   storePiece,
	output logic                   rearmHold,
	output logic                   resetBlocks,
	output logic                   pause
);

	tetrisPkg::gameStateT state;
	tetrisPkg::gameStateT nextState;

	// State register --------
	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= tetrisPkg::waitStart;
		end
		else
		begin
			state <= nextState;
		end
	end

	// Next state --------
	always_comb
	begin
		nextState = state;
		case (state)
			tetrisPkg::waitStart:
			begin
				if (startPress)
				begin
					nextState = tetrisPkg::spawn;
				end
			end
			tetrisPkg::spawn:
			begin
				nextState = tetrisPkg::falling;
			end
			tetrisPkg::falling:
			begin
				// Quit wins over hold, hold over pause, pause over landing.
				if (quitPress)
				begin
					nextState = tetrisPkg::waitStart;
				end
				else if (holdPress && canHold)
				begin
					nextState = tetrisPkg::holding;
				end
				else if (pausePress)
				begin
					nextState = tetrisPkg::paused;
				end
				else if (hitBottom)
				begin
					nextState = tetrisPkg::landed;
				end
			end
			tetrisPkg::holding:
			begin
				// A full slot hands its piece straight back, an empty one needs a new piece.
				nextState = heldValid ? tetrisPkg::falling : tetrisPkg::spawn;
			end
			tetrisPkg::landed:
			begin
				nextState = tetrisPkg::spawn;
			end
			tetrisPkg::paused:
			begin
				if (quitPress)
				begin
					nextState = tetrisPkg::waitStart;
				end
				else if (pausePress)
				begin
					nextState = tetrisPkg::falling;  // Resume with the same piece.
				end
			end
			default:
			begin
				nextState = tetrisPkg::waitStart;
			end
		endcase
	end

	// Strobes to the neighbours --------
	assign pickPiece   = (state == tetrisPkg::spawn);
	assign resetBlocks = (state == tetrisPkg::spawn);    // Board places a new piece.
	assign storePiece  = (state == tetrisPkg::holding);
	assign rearmHold   = (state == tetrisPkg::landed);
	assign pause       = (state == tetrisPkg::waitStart) || (state == tetrisPkg::paused);

	// Active piece --------
	// Loaded from the generator on spawn, or from the old slot contents
	// on the same edge that stores the current piece in the slot.
	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			activeShape  <= '0;
			activeSprite <= '0;
		end
		else if (pickPiece)
		begin
			activeShape  <= nextShape;
			activeSprite <= nextSprite;
		end
		else if (storePiece && heldValid)
		begin
			activeShape  <= heldShape;
			activeSprite <= heldSprite;
		end
	end

endmodule

// ==== design/holdSlot.sv ====
`timescale 1ns/100ps

module holdSlot
(
	input  logic                   Clk,
	input  logic                   arstN,
	input  logic                   storePiece,
	input  logic                   rearmHold,
	input  tetrisPkg::pieceShapeT  activeShape,
	input  tetrisPkg::spriteIndexT activeSprite,
	output tetrisPkg::pieceShapeT  heldShape,
	output tetrisPkg::spriteIndexT heldSprite,
	output logic                   heldValid,
	output logic                   canHold
);

	// Held piece --------
	// Only reset empties the slot, a store always replaces it.
	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			heldShape  <= '0;
			heldSprite <= '0;
			heldValid  <= 1'b0;
		end
		else if (storePiece)
		begin
			heldShape  <= activeShape;   // Active piece moves into the slot.
			heldSprite <= activeSprite;
			heldValid  <= 1'b1;
		end
	end

	// One hold per piece --------
	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			canHold <= 1'b1;
		end
		else if (storePiece)
		begin
			canHold <= 1'b0;  // Spent until the piece lands.
		end
		else if (rearmHold)
		begin
			canHold <= 1'b1;
		end
	end

endmodule

// ==== design/pieceGenerator.sv ====
`timescale 1ns/100ps

module pieceGenerator
(
	input  logic                   Clk,
	input  logic                   arstN,
	input  logic                   pickPiece,
	output tetrisPkg::pieceShapeT  nextShape,
	output tetrisPkg::spriteIndexT nextSprite
);

	logic [15:0]          lfsr;
	logic [15:0]          lfsrNext;
	logic                 feedback;
	tetrisPkg::pieceKindT kind;

	// LFSR step --------
	// XOR of the tapped bits enters at the top as the register shifts right.
	assign feedback = ^(lfsr & tetrisPkg::lfsrTaps);
	assign lfsrNext = {feedback, lfsr[15:1]};

	// The register only moves when a piece is taken, so the sequence
	// does not depend on how long a piece falls.
	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			lfsr <= tetrisPkg::lfsrSeed;
		end
		else if (pickPiece)
		begin
			lfsr <= lfsrNext;
		end
	end

	// Preview --------
	// Kind is the current value modulo 7.
	assign kind = tetrisPkg::pieceKindT'(lfsr % 16'(tetrisPkg::numKinds));

	// Table lookup that is valid in every cycle.
	assign nextShape  = tetrisPkg::pieceShapes[kind];
	assign nextSprite = tetrisPkg::pieceSprites[kind];

endmodule

// ==== design/keyDecoder.sv ====
`timescale 1ns/100ps

module keyDecoder
(
	input  logic       Clk,
	input  logic       arstN,
	input  logic [7:0] keycode,
	output logic       startPress,
	output logic       pausePress,
	output logic       holdPress,
	output logic       quitPress
);

	logic [7:0] prevKey;  // Keycode seen on the last edge.
	logic       newKey;

	// A press counts only when the code differs from the previous sample,
	// so a key held down gives a single pulse.
	assign newKey = (keycode != prevKey);

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			prevKey    <= tetrisPkg::keyIdle;
			startPress <= 1'b0;
			pausePress <= 1'b0;
			holdPress  <= 1'b0;
			quitPress  <= 1'b0;
		end
		else
		begin
			prevKey    <= keycode;
			// Unknown codes and keyIdle match none of these.
			startPress <= newKey && (keycode == tetrisPkg::keyStart);
			pausePress <= newKey && (keycode == tetrisPkg::keyPause);
			holdPress  <= newKey && (keycode == tetrisPkg::keyHold);
			quitPress  <= newKey && (keycode == tetrisPkg::keyQuit);
		end
	end

endmodule

// ==== design/tetrisPkg.sv ====
package tetrisPkg;

	// Basic types --------
	typedef logic [15:0] pieceShapeT;   // 4x4 bitmap with row 0 in the high nibble.
	typedef logic [5:0]  spriteIndexT;  // Colour sprite of a piece.
	typedef logic [2:0]  pieceKindT;    // Kinds 0 to 6.

	// States of the game controller.
	typedef enum logic [2:0]
	{
		waitStart,
		spawn,
		falling,
		holding,
		landed,
		paused
	} gameStateT;

	// Scan codes --------
	localparam logic [7:0] keyIdle  = 8'h00;  // No key is down.
	localparam logic [7:0] keyStart = 8'h2C;  // Space.
	localparam logic [7:0] keyPause = 8'h13;
	localparam logic [7:0] keyHold  = 8'h2B;
	localparam logic [7:0] keyQuit  = 8'h29;

	// Piece tables --------
	// Spawn orientation of each kind, in the order I, O, T, S, Z, J, L.
	localparam pieceShapeT pieceShapes [0:6] = '{
		16'h0F00,  // I.
		16'h0660,  // O.
		16'h0E40,  // T.
		16'h06C0,  // S.
		16'h0C60,  // Z.
		16'h0E20,  // J.
		16'h0E80   // L.
	};

	// Sprite of each kind, same order as above.
	localparam spriteIndexT pieceSprites [0:6] = '{
		6'd1,
		6'd2,
		6'd3,
		6'd4,
		6'd5,
		6'd6,
		6'd7
	};

	// LFSR --------
	// Fibonacci form of x^16 + x^14 + x^13 + x^11 that shifts right.
	// Taps land on bits 0, 2, 3 and 5 of the register.
	localparam logic [15:0] lfsrSeed = 16'hACE1;
	localparam logic [15:0] lfsrTaps = 16'h002D;

	// Number of piece kinds.
	localparam int numKinds = 7;

endpackage
